/* Makefile */
# Verilator build and run for the memory_unit testbench

VERILATOR ?= verilator
TOP       ?= memory_unit_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/memory_unit_input.txt */
test address data we expected_q
vram32_first 0C00000 00000000 0 A5000000
vram32_mid 0C00210 00000000 0 A5000210
vram32_last 0C0041F 00000000 0 A500041F
vram8_first 0C00420 00000000 0 0000005A
vram8_mid 0C01420 00000000 0 0000004A
vram8_last 0C02421 00000000 0 0000007B
spr_first 0C02422 00000000 0 0000012C
spr_mid 0C024A2 00000000 0 000001AC
spr_last 0C02521 00000000 0 000001D3
rom_first 0C02522 00000000 0 C0DE0000
rom_mid 0C02622 00000000 0 C0DE0100
rom_last 0C02721 00000000 0 C0DE01FF
vram32_write 0C00105 DEADBEEF 1 00000000
vram8_write 0C02000 12345678 1 00000000
spr_write 0C02500 FFFFFF5A 1 00000000
rom_write 0C02600 CAFEF00D 1 00000000
boot_mode 0C02741 00000000 0 00000001
uart_tx_a5 0C02723 000000A5 1 00000000
uart_rx_a5 0C02722 00000000 0 000000A5
uart_tx_3c 0C02723 0000003C 1 00000000
uart_rx_3c 0C02722 00000000 0 0000003C
unmapped_sdram 0000000 00000000 0 00000000
unmapped_flash 0800000 00000000 0 00000000
unmapped_io 0C02742 00000000 0 00000000
unmapped_top 7FFFFFF 00000000 0 00000000

/* dv/memory_unit_tb.sv */
// Must run from the project root to find the access list, and models every memory as same-cycle q
`timescale 1ns/1ns

module memory_unit_tb;

    import bus_map_pkg::*;
    import uart_pkg::*;

    // Serial frame plus margin, the slowest access in the list
    localparam int ENTRY_CYCLES = 12 * CLKS_PER_BIT + 20;
    localparam int RESET_CYCLES = 16;
    // Drive edge to the negedge where done is first seen
    localparam int IMMEDIATE_CYCLES = 3;
    // Start kept high past done on TX writes
    localparam int TX_HOLD_CYCLES = 4;

    logic          clk;
    logic          reset;
    bus_addr_t     bus_addr;
    bus_word_t     bus_data;
    logic          bus_we;
    logic          bus_start;
    bus_word_t     bus_q;
    logic          bus_done;
    win_addr_t     vram32_addr;
    vram32_data_t  vram32_d;
    logic          vram32_we;
    vram32_data_t  vram32_q;
    win_addr_t     vram8_addr;
    vram8_data_t   vram8_d;
    logic          vram8_we;
    vram8_data_t   vram8_q;
    win_addr_t     vramspr_addr;
    vramspr_data_t vramspr_d;
    logic          vramspr_we;
    vramspr_data_t vramspr_q;
    rom_addr_t     rom_addr;
    bus_word_t     rom_q;
    // TX looped straight back into RX
    logic          uart_line;
    logic          rx_irq;
    logic          boot_mode;

    // ------------------------------------------------------------------
    // Access list and bookkeeping
    // ------------------------------------------------------------------

    logic [8*24-1:0] entry_name[$];
    bus_addr_t       entry_addr[$];
    bus_word_t       entry_data[$];
    logic            entry_we[$];
    bus_word_t       entry_q[$];

    int          error_count;
    int          failed_tests;
    int          irq_count;
    int          tx_sent;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] rand_state;

    // ------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------

    // Each pattern folds in every offset bit
    assign vram32_q  = 32'hA500_0000 ^ 32'(vram32_addr);
    assign vram8_q   = 8'h5A ^ vram8_addr[7:0] ^ 8'(vram8_addr[13:8]);
    assign vramspr_q = 9'h12C ^ vramspr_addr[8:0] ^ 9'(vramspr_addr[13:9]);
    assign rom_q     = 32'hC0DE_0000 ^ 32'(rom_addr);
    assign boot_mode = 1'b1;

    memory_unit uut (
        .clk            (clk),
        .reset          (reset),
        .i_bus_addr     (bus_addr),
        .i_bus_data     (bus_data),
        .i_bus_we       (bus_we),
        .i_bus_start    (bus_start),
        .o_bus_q        (bus_q),
        .o_bus_done     (bus_done),
        .o_vram32_addr  (vram32_addr),
        .o_vram32_d     (vram32_d),
        .o_vram32_we    (vram32_we),
        .i_vram32_q     (vram32_q),
        .o_vram8_addr   (vram8_addr),
        .o_vram8_d      (vram8_d),
        .o_vram8_we     (vram8_we),
        .i_vram8_q      (vram8_q),
        .o_vramspr_addr (vramspr_addr),
        .o_vramspr_d    (vramspr_d),
        .o_vramspr_we   (vramspr_we),
        .i_vramspr_q    (vramspr_q),
        .o_rom_addr     (rom_addr),
        .i_rom_q        (rom_q),
        .i_uart_rx      (uart_line),
        .o_uart_tx      (uart_line),
        .o_uart_rx_irq  (rx_irq),
        .i_boot_mode    (boot_mode)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // One count per received byte
    always @(negedge clk)
        if (rx_irq === 1'b1)
            irq_count <= irq_count + 1;

    // Watchdog, armed once the list length is known
    initial
    begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit)
            @(posedge clk);
        $display("Timeout after %0d cycles with accesses still pending", cycle_count);
        $display("sim failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string signal, input bus_word_t got,
                                   input bus_word_t expected);
        $display("Mismatch at %0t ns: %0s got %h expected %h", $time, signal, got, expected);
        error_count++;
    endtask

    task automatic report_failure(input string text);
        $display("%0s", text);
        error_count++;
    endtask

    task automatic load_access_list();
        int              fd;
        logic [8*24-1:0] name;
        bus_addr_t       addr;
        bus_word_t       data;
        logic            we;
        bus_word_t       q;
        begin
            fd = $fopen("dv/memory_unit_input.txt", "r");
            if (fd == 0)
                report_failure("Cannot open dv/memory_unit_input.txt");
            else
            begin
                // Column header line
                void'($fscanf(fd, "%s %s %s %s %s", name, name, name, name, name));
                while ($fscanf(fd, "%s %h %h %h %h", name, addr, data, we, q) == 5)
                begin
                    entry_name.push_back(name);
                    entry_addr.push_back(addr);
                    entry_data.push_back(data);
                    entry_we.push_back(we);
                    entry_q.push_back(q);
                end
                $fclose(fd);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Port checks against the address map
    // ------------------------------------------------------------------

    task automatic check_ports(input bus_addr_t addr, input bus_word_t data, input logic we);
        logic wr32;
        logic wr8;
        logic wrspr;
        begin
            wr32  = we && (addr >= VRAM32_BASE) && (addr < VRAM32_BASE + VRAM32_SIZE);
            wr8   = we && (addr >= VRAM8_BASE) && (addr < VRAM8_BASE + VRAM8_SIZE);
            wrspr = we && (addr >= VRAMSPR_BASE) && (addr < VRAMSPR_BASE + VRAMSPR_SIZE);
            if (vram32_we !== wr32)
                report_mismatch("o_vram32_we", 32'(vram32_we), 32'(wr32));
            if (vram8_we !== wr8)
                report_mismatch("o_vram8_we", 32'(vram8_we), 32'(wr8));
            if (vramspr_we !== wrspr)
                report_mismatch("o_vramspr_we", 32'(vramspr_we), 32'(wrspr));
            if (wr32 && vram32_addr !== win_addr_t'(addr - VRAM32_BASE))
                report_mismatch("o_vram32_addr", 32'(vram32_addr), 32'(addr - VRAM32_BASE));
            if (wr32 && vram32_d !== data)
                report_mismatch("o_vram32_d", vram32_d, data);
            if (wr8 && vram8_addr !== win_addr_t'(addr - VRAM8_BASE))
                report_mismatch("o_vram8_addr", 32'(vram8_addr), 32'(addr - VRAM8_BASE));
            // Narrow windows keep the low data bits
            if (wr8 && vram8_d !== vram8_data_t'(data))
                report_mismatch("o_vram8_d", 32'(vram8_d), 32'(vram8_data_t'(data)));
            if (wrspr && vramspr_addr !== win_addr_t'(addr - VRAMSPR_BASE))
                report_mismatch("o_vramspr_addr", 32'(vramspr_addr), 32'(addr - VRAMSPR_BASE));
            if (wrspr && vramspr_d !== vramspr_data_t'(data))
                report_mismatch("o_vramspr_d", 32'(vramspr_d), 32'(vramspr_data_t'(data)));
        end
    endtask

    // ------------------------------------------------------------------
    // One bus access
    // ------------------------------------------------------------------

    task automatic run_access(input int idx);
        bus_addr_t addr;
        bus_word_t data;
        logic      we;
        logic      is_tx;
        logic      line_dropped;
        int        cycles;
        int        errors_before;
        begin
            addr          = entry_addr[idx];
            data          = entry_data[idx];
            we            = entry_we[idx];
            is_tx         = we && (addr == UART_TX_ADDR);
            line_dropped  = 1'b0;
            cycles        = 0;
            errors_before = error_count;
            @(posedge clk);
            bus_addr  <= addr;
            bus_data  <= data;
            bus_we    <= we;
            bus_start <= 1'b1;
            // Start held until done, ports checked each cycle
            do
            begin
                @(negedge clk);
                cycles++;
                check_ports(addr, data, we);
            end
            while (bus_done !== 1'b1);
            // Window write q is don't care
            if ((!we || is_tx) && bus_q !== entry_q[idx])
                report_mismatch("o_bus_q", bus_q, entry_q[idx]);
            if (!is_tx && cycles != IMMEDIATE_CYCLES)
                report_failure($sformatf("%0s completed after %0d cycles instead of %0d",
                                         entry_name[idx], cycles, IMMEDIATE_CYCLES));
            if (is_tx && cycles < 10 * CLKS_PER_BIT)
                report_failure($sformatf("%0s completed after %0d cycles, before the frame",
                                         entry_name[idx], cycles));
            // Held start probes the TX re-arm
            if (is_tx)
                repeat (TX_HOLD_CYCLES)
                begin
                    @(negedge clk);
                    if (bus_done !== 1'b0)
                        report_failure("Second done pulse while start was held");
                end
            @(posedge clk);
            bus_start <= 1'b0;
            bus_we    <= 1'b0;
            @(negedge clk);
            if (bus_done !== 1'b0)
                report_failure("Done stayed high for more than one cycle");
            if (is_tx)
            begin
                tx_sent++;
                // A repeated frame would pull the line low here
                repeat (2 * CLKS_PER_BIT)
                begin
                    @(negedge clk);
                    if (uart_line !== 1'b1)
                        line_dropped = 1'b1;
                end
                if (line_dropped)
                    report_failure("A second serial frame started after the TX access");
                if (irq_count != tx_sent)
                    report_failure($sformatf("Saw %0d RX interrupts for %0d bytes sent",
                                             irq_count, tx_sent));
            end
            if (error_count == errors_before)
                $display("%0s ok", entry_name[idx]);
            else
            begin
                $display("%0s FAILED", entry_name[idx]);
                failed_tests++;
            end
        end
    endtask

    initial
    begin
        clk          = 1'b0;
        reset        = 1'b1;
        bus_addr     = '0;
        bus_data     = '0;
        bus_we       = 1'b0;
        bus_start    = 1'b0;
        error_count  = 0;
        failed_tests = 0;
        irq_count    = 0;
        tx_sent      = 0;
        cycle_count  = 0;
        rand_state   = 32'hbc3dd7fc;
        load_access_list();
        if (entry_addr.size() == 0)
            report_failure("The access list holds no entries");
        cycle_limit = entry_addr.size() * ENTRY_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < entry_addr.size(); i++)
        begin
            run_access(i);
            // Idle gap of 0 to 3 cycles
            rand_state = lcg_next(rand_state);
            repeat (int'(rand_state[31:30])) @(posedge clk);
        end
        if (irq_count != tx_sent)
            report_failure("RX interrupts outside the TX accesses");
        $display("Tests %0d, failed %0d, errors %0d", entry_addr.size(), failed_tests,
                 error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* rtl/bus_map_pkg.sv */
// CPU bus map for windows and I/O registers where windows must stay below the register block
package bus_map_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------

    // Word address on the CPU bus
    typedef logic [26:0] bus_addr_t;

    // Read and write data word
    typedef logic [31:0] bus_word_t;

    // ------------------------------------------------------------------
    // Window payloads and offsets
    // ------------------------------------------------------------------

    // One entry per window, widths set by the video memories
    typedef logic [31:0] vram32_data_t;
    typedef logic [7:0]  vram8_data_t;
    typedef logic [8:0]  vramspr_data_t;

    // Offset inside a video window
    typedef logic [13:0] win_addr_t;

    // Offset inside the instruction ROM
    typedef logic [8:0]  rom_addr_t;

    // ------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------

    // Windows are packed back to back from C00000
    localparam bus_addr_t VRAM32_BASE  = 27'hC00000;
    localparam bus_addr_t VRAM32_SIZE  = 27'h000420;
    localparam bus_addr_t VRAM8_BASE   = 27'hC00420;
    localparam bus_addr_t VRAM8_SIZE   = 27'h002002;
    localparam bus_addr_t VRAMSPR_BASE = 27'hC02422;
    localparam bus_addr_t VRAMSPR_SIZE = 27'h000100;
    localparam bus_addr_t ROM_BASE     = 27'hC02522;
    localparam bus_addr_t ROM_SIZE     = 27'h000200;

    // Single-word I/O registers just above the ROM
    localparam bus_addr_t UART_RX_ADDR   = 27'hC02722;
    localparam bus_addr_t UART_TX_ADDR   = 27'hC02723;
    localparam bus_addr_t BOOT_MODE_ADDR = 27'hC02741;

endpackage

/* rtl/bus_responder.sv */
// Bus completion logic where i_bus_start must stay high until o_bus_done and then drop for a cycle
`timescale 1ns/1ns

module bus_responder (
    input  logic                       clk,
    input  logic                       reset,
    input  bus_map_pkg::bus_addr_t     i_bus_addr,
    input  bus_map_pkg::bus_word_t     i_bus_data,
    input  logic                       i_bus_we,
    input  logic                       i_bus_start,
    input  logic                       i_vram32_hit,
    input  logic                       i_vram8_hit,
    input  logic                       i_vramspr_hit,
    input  logic                       i_rom_hit,
    input  bus_map_pkg::vram32_data_t  i_vram32_q,
    input  bus_map_pkg::vram8_data_t   i_vram8_q,
    input  bus_map_pkg::vramspr_data_t i_vramspr_q,
    input  bus_map_pkg::bus_word_t     i_rom_q,
    input  uart_pkg::uart_byte_t       i_rx_byte,
    input  logic                       i_tx_done,
    input  logic                       i_boot_mode,
    output logic                       o_tx_valid,
    output uart_pkg::uart_byte_t       o_tx_byte,
    output bus_map_pkg::bus_word_t     o_bus_q,
    output logic                       o_bus_done
);

    import bus_map_pkg::*;
    import uart_pkg::*;

    // Write to the TX register, the only access with variable latency
    logic      tx_access;
    // Every other address, mapped or not, completes right away
    logic      instant_access;
    logic      done_next;
    // Blocks a second completion while start is still held
    logic      access_served;
    bus_word_t read_q;

    assign tx_access      = (i_bus_addr == UART_TX_ADDR) && i_bus_we;
    assign instant_access = !tx_access;

    // ------------------------------------------------------------------
    // UART TX request
    // ------------------------------------------------------------------

    // Level request, uart_tx handles its own re-arm
    assign o_tx_valid = i_bus_start && tx_access;
    assign o_tx_byte  = uart_byte_t'(i_bus_data);

    // ------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------

    // Narrow sources zero-extended, TX and unmapped read as zero
    always_comb
    begin
        read_q = '0;
        if (i_vram32_hit)
            read_q = i_vram32_q;
        else if (i_vram8_hit)
            read_q = bus_word_t'(i_vram8_q);
        else if (i_vramspr_hit)
            read_q = bus_word_t'(i_vramspr_q);
        else if (i_rom_hit)
            read_q = i_rom_q;
        else if (i_bus_addr == UART_RX_ADDR)
            read_q = bus_word_t'(i_rx_byte);
        else if (i_bus_addr == BOOT_MODE_ADDR)
            read_q = bus_word_t'(i_boot_mode);
    end

    // ------------------------------------------------------------------
    // Completion timing
    // ------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done_next     <= 1'b0;
            access_served <= 1'b0;
            o_bus_done    <= 1'b0;
            o_bus_q       <= '0;
        end
        else
        begin
            // Tracks the address every cycle, valid with the done pulse
            o_bus_q    <= read_q;
            o_bus_done <= done_next;
            done_next  <= 1'b0;
            if (!i_bus_start)
                access_served <= 1'b0;
            else if (!access_served && (instant_access || i_tx_done))
            begin
                done_next     <= 1'b1;
                access_served <= 1'b1;
            end
        end
    end

endmodule

/* rtl/memory_unit.sv */
// CPU bus decoder top where the memories return q combinationally from their address inputs
`timescale 1ns/1ns

module memory_unit (
    input  logic                       clk,
    input  logic                       reset,
    // CPU bus
    input  bus_map_pkg::bus_addr_t     i_bus_addr,
    input  bus_map_pkg::bus_word_t     i_bus_data,
    input  logic                       i_bus_we,
    input  logic                       i_bus_start,
    output bus_map_pkg::bus_word_t     o_bus_q,
    output logic                       o_bus_done,
    // VRAM32 port
    output bus_map_pkg::win_addr_t     o_vram32_addr,
    output bus_map_pkg::vram32_data_t  o_vram32_d,
    output logic                       o_vram32_we,
    input  bus_map_pkg::vram32_data_t  i_vram32_q,
    // VRAM8 port
    output bus_map_pkg::win_addr_t     o_vram8_addr,
    output bus_map_pkg::vram8_data_t   o_vram8_d,
    output logic                       o_vram8_we,
    input  bus_map_pkg::vram8_data_t   i_vram8_q,
    // Sprite RAM port
    output bus_map_pkg::win_addr_t     o_vramspr_addr,
    output bus_map_pkg::vramspr_data_t o_vramspr_d,
    output logic                       o_vramspr_we,
    input  bus_map_pkg::vramspr_data_t i_vramspr_q,
    // Instruction ROM, read only
    output bus_map_pkg::rom_addr_t     o_rom_addr,
    input  bus_map_pkg::bus_word_t     i_rom_q,
    // Serial port
    input  logic                       i_uart_rx,
    output logic                       o_uart_tx,
    output logic                       o_uart_rx_irq,
    input  logic                       i_boot_mode
);

    import bus_map_pkg::*;
    import uart_pkg::*;

    logic       vram32_hit;
    logic       vram8_hit;
    logic       vramspr_hit;
    logic       rom_hit;
    logic       tx_valid;
    logic       tx_done;
    uart_byte_t tx_byte;
    uart_byte_t rx_byte;

    // ------------------------------------------------------------------
    // Memory windows
    // ------------------------------------------------------------------

    region_port #(.BASE(VRAM32_BASE), .SIZE(VRAM32_SIZE),
                  .T_DATA(vram32_data_t), .T_ADDR(win_addr_t)) u_vram32 (
        .i_bus_addr (i_bus_addr),    .i_bus_data (i_bus_data), .i_bus_we (i_bus_we),
        .o_hit      (vram32_hit),    .o_addr     (o_vram32_addr),
        .o_d        (o_vram32_d),    .o_we       (o_vram32_we)
    );

    region_port #(.BASE(VRAM8_BASE), .SIZE(VRAM8_SIZE),
                  .T_DATA(vram8_data_t), .T_ADDR(win_addr_t)) u_vram8 (
        .i_bus_addr (i_bus_addr),    .i_bus_data (i_bus_data), .i_bus_we (i_bus_we),
        .o_hit      (vram8_hit),     .o_addr     (o_vram8_addr),
        .o_d        (o_vram8_d),     .o_we       (o_vram8_we)
    );

    region_port #(.BASE(VRAMSPR_BASE), .SIZE(VRAMSPR_SIZE),
                  .T_DATA(vramspr_data_t), .T_ADDR(win_addr_t)) u_vramspr (
        .i_bus_addr (i_bus_addr),    .i_bus_data (i_bus_data), .i_bus_we (i_bus_we),
        .o_hit      (vramspr_hit),   .o_addr     (o_vramspr_addr),
        .o_d        (o_vramspr_d),   .o_we       (o_vramspr_we)
    );

    // ROM has no write path
    region_port #(.BASE(ROM_BASE), .SIZE(ROM_SIZE),
                  .T_DATA(bus_word_t), .T_ADDR(rom_addr_t)) u_rom (
        .i_bus_addr (i_bus_addr),    .i_bus_data (i_bus_data), .i_bus_we (i_bus_we),
        .o_hit      (rom_hit),       .o_addr     (o_rom_addr),
        .o_d        (),              .o_we       ()
    );

    // ------------------------------------------------------------------
    // UART and bus response
    // ------------------------------------------------------------------

    uart_tx u_uart_tx (
        .clk (clk), .reset (reset), .i_tx_valid (tx_valid), .i_tx_byte (tx_byte),
        .o_tx_serial (o_uart_tx), .o_tx_done (tx_done)
    );

    // Valid pulse doubles as the receive interrupt
    uart_rx u_uart_rx (
        .clk (clk), .reset (reset), .i_rx_serial (i_uart_rx),
        .o_rx_valid (o_uart_rx_irq), .o_rx_byte (rx_byte)
    );

    bus_responder u_responder (
        .clk (clk), .reset (reset),
        .i_bus_addr (i_bus_addr), .i_bus_data (i_bus_data),
        .i_bus_we (i_bus_we), .i_bus_start (i_bus_start),
        .i_vram32_hit (vram32_hit), .i_vram8_hit (vram8_hit),
        .i_vramspr_hit (vramspr_hit), .i_rom_hit (rom_hit),
        .i_vram32_q (i_vram32_q), .i_vram8_q (i_vram8_q),
        .i_vramspr_q (i_vramspr_q), .i_rom_q (i_rom_q),
        .i_rx_byte (rx_byte), .i_tx_done (tx_done), .i_boot_mode (i_boot_mode),
        .o_tx_valid (tx_valid), .o_tx_byte (tx_byte),
        .o_bus_q (o_bus_q), .o_bus_done (o_bus_done)
    );

endmodule

/* rtl/region_port.sv */
// Combinational window decode where SIZE must fit in T_ADDR and the write enable follows i_bus_we
`timescale 1ns/1ns

module region_port #(
    parameter bus_map_pkg::bus_addr_t BASE = '0,
    parameter bus_map_pkg::bus_addr_t SIZE = '0,
    parameter type T_DATA = logic,
    parameter type T_ADDR = logic
) (
    input  bus_map_pkg::bus_addr_t i_bus_addr,
    input  bus_map_pkg::bus_word_t i_bus_data,
    input  logic                   i_bus_we,
    output logic                   o_hit,
    output T_ADDR                  o_addr,
    output T_DATA                  o_d,
    output logic                   o_we
);

    import bus_map_pkg::*;

    // Distance from the window base, only meaningful on a hit
    bus_addr_t offset;

    assign offset = i_bus_addr - BASE;

    // Lower bound checked on the raw address so wrap-around cannot alias
    assign o_hit = (i_bus_addr >= BASE) && (offset < SIZE);

    // ------------------------------------------------------------------
    // Memory port
    // ------------------------------------------------------------------

    // Offset truncated to the memory depth
    assign o_addr = o_hit ? T_ADDR'(offset) : '0;

    // Low bits of the bus word for narrow memories
    assign o_d = o_hit ? T_DATA'(i_bus_data) : '0;

    // No write outside the window
    assign o_we = o_hit & i_bus_we;

endmodule

/* rtl/uart_pkg.sv */
// Serial settings for the 8N1 UART where CLKS_PER_BIT must be a power of two of at least 4
package uart_pkg;

    // ------------------------------------------------------------------
    // Bit timing
    // ------------------------------------------------------------------

    // clk cycles per serial bit, shared by transmitter and receiver
    localparam int CLKS_PER_BIT = 8;

    // ------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------

    // One data byte per frame, sent LSB first
    typedef logic [7:0] uart_byte_t;

endpackage

/* rtl/uart_rx.sv */
// 8N1 receiver sampling mid-bit where a frame with a low stop bit is dropped without a valid pulse
`timescale 1ns/1ns

module uart_rx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_rx_serial,
    output logic                 o_rx_valid,
    output uart_pkg::uart_byte_t o_rx_byte
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    // Half a bit, lands the later samples in the middle of each bit
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= i_rx_serial;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end
        else
        begin
            o_rx_valid <= 1'b0;
            clk_cnt    <= (clk_cnt == CNT_LAST) ? '0 : clk_cnt + 1'b1;
            case (state)
                RX_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    // Falling edge may be a start bit
                    if (!rx_sync)
                        state <= RX_START;
                end
                RX_START:
                    if (clk_cnt == CNT_HALF)
                    begin
                        clk_cnt <= '0;
                        // Line back high at mid-start is a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                RX_DATA:
                    if (clk_cnt == CNT_LAST)
                    begin
                        // LSB first, shifts down into place
                        o_rx_byte <= {rx_sync, o_rx_byte[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                default:
                    if (clk_cnt == CNT_LAST)
                    begin
                        o_rx_valid <= rx_sync;
                        state      <= RX_IDLE;
                    end
            endcase
        end
    end

endmodule

/* rtl/uart_tx.sv */
// 8N1 transmitter that sends once per i_tx_valid level and waits for it to drop before re-arming
`timescale 1ns/1ns

module uart_tx (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_tx_valid,
    input  uart_pkg::uart_byte_t i_tx_byte,
    output logic                 o_tx_serial,
    output logic                 o_tx_done
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP, TX_REARM} tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    // Shifts right, bit 0 is the next bit on the line
    uart_byte_t       tx_shift;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= TX_IDLE;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            o_tx_serial <= 1'b1;
            o_tx_done   <= 1'b0;
        end
        else
        begin
            // Done is a single-cycle pulse
            o_tx_done <= 1'b0;
            clk_cnt   <= (clk_cnt == CNT_LAST) ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE:
                begin
                    clk_cnt     <= '0;
                    bit_idx     <= '0;
                    o_tx_serial <= 1'b1;
                    if (i_tx_valid)
                    begin
                        // Latch the byte and drive the start bit
                        tx_shift    <= i_tx_byte;
                        o_tx_serial <= 1'b0;
                        state       <= TX_START;
                    end
                end
                TX_START:
                    if (clk_cnt == CNT_LAST)
                    begin
                        o_tx_serial <= tx_shift[0];
                        tx_shift    <= tx_shift >> 1;
                        state       <= TX_DATA;
                    end
                TX_DATA:
                    if (clk_cnt == CNT_LAST)
                    begin
                        if (bit_idx == 3'd7)
                        begin
                            // Stop bit
                            o_tx_serial <= 1'b1;
                            state       <= TX_STOP;
                        end
                        else
                        begin
                            o_tx_serial <= tx_shift[0];
                            tx_shift    <= tx_shift >> 1;
                            bit_idx     <= bit_idx + 1'b1;
                        end
                    end
                TX_STOP:
                    if (clk_cnt == CNT_LAST)
                    begin
                        o_tx_done <= 1'b1;
                        state     <= TX_REARM;
                    end
                // Held request must be released before the next frame
                default:
                    if (!i_tx_valid)
                        state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* sources.f */
rtl/bus_map_pkg.sv
rtl/uart_pkg.sv
rtl/region_port.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/bus_responder.sv
rtl/memory_unit.sv
dv/memory_unit_tb.sv
